// File: filelist.f
verilog/agu_pkg.sv
verilog/gen_cfg_if.sv
verilog/addr_gen.sv
verilog/addr_gen2.sv
verilog/data_mem.sv
verilog/agu_top.sv
sim/tb_agu.sv

// File: Makefile
SRCS := $(shell cat filelist.f)

.PHONY: all run clean

all: run

obj_dir/Vtb_agu: filelist.f $(SRCS)
	verilator --binary --timing --assert --top-module tb_agu -f filelist.f

run: obj_dir/Vtb_agu
	./obj_dir/Vtb_agu | tee sim.log
	grep -q "TEST PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

// File: sim/tb_agu.sv
`timescale 1ns/100ps

module tb_agu;

   localparam int ADDR_W     = agu_pkg::ADDR_W_DEF;
   localparam int PERIOD_W   = agu_pkg::PERIOD_W_DEF;
   localparam int DATA_W     = agu_pkg::DATA_W_DEF;
   localparam int DEPTH      = 2 ** ADDR_W;
   localparam int CLK_PERIOD = 100;
   // worst case of one run: 5 patterns of delay 3, 3 x 4 cycles, reload slack
   localparam int RUN_CYCLES = 150;
   localparam int NUM_RUNS   = 10;

   logic                       clk_i;
   logic                       rst_i;
   logic                       run_i;
   logic                       wr_en_i;
   logic        [ADDR_W-1:0]   wr_addr_i;
   logic        [DATA_W-1:0]   wr_data_i;
   logic        [ADDR_W-1:0]   iterations_i;
   logic        [PERIOD_W-1:0] period_i;
   logic        [PERIOD_W-1:0] duty_i;
   logic        [PERIOD_W-1:0] delay_i;
   logic        [ADDR_W-1:0]   start_i;
   logic signed [ADDR_W-1:0]   shift_i;
   logic signed [ADDR_W-1:0]   incr_i;
   logic        [ADDR_W-1:0]   iterations2_i;
   logic        [PERIOD_W-1:0] period2_i;
   logic signed [ADDR_W-1:0]   shift2_i;
   logic signed [ADDR_W-1:0]   incr2_i;
   logic        [ADDR_W-1:0]   rd_addr_o;
   logic        [DATA_W-1:0]   rd_data_o;
   logic                       rd_valid_o;
   logic                       done_o;

   // configuration of the current run, seen by the model
   logic [ADDR_W-1:0]   c_it;
   logic [PERIOD_W-1:0] c_per;
   logic [PERIOD_W-1:0] c_duty;
   logic [PERIOD_W-1:0] c_delay;
   logic [ADDR_W-1:0]   c_start;
   logic [ADDR_W-1:0]   c_shift;
   logic [ADDR_W-1:0]   c_incr;
   logic [ADDR_W-1:0]   c_it2;
   logic [PERIOD_W-1:0] c_per2;
   logic [ADDR_W-1:0]   c_shift2;
   logic [ADDR_W-1:0]   c_incr2;

   logic [ADDR_W-1:0] exp_q [$];
   logic [DATA_W-1:0] mirror [DEPTH];
   logic [ADDR_W-1:0] exp_addr;
   logic [DATA_W-1:0] exp_data;
   logic              exp_empty;
   logic              pop_pend;
   string             test_name;
   integer            seed;
   int                err_addr;
   int                err_data;
   int                err_other;

   agu_top #(.ADDR_W(ADDR_W), .PERIOD_W(PERIOD_W), .DATA_W(DATA_W)) DUT (.*);

   always #(CLK_PERIOD / 2) clk_i = !clk_i;

   task automatic refresh_head();
      exp_empty = (exp_q.size() == 0);
      if (!exp_empty) begin
         exp_addr = exp_q[0];
         exp_data = mirror[exp_q[0]];
      end
   endtask

   // one inner pattern from a base address
   task automatic push_pattern(input logic [ADDR_W-1:0] base);
      logic [ADDR_W-1:0] a;
      a = base;
      for (int i = 0; i < int'(c_it); i++) begin
         for (int p = 0; p < int'(c_per); p++) begin
            if (p < int'(c_duty)) begin
               exp_q.push_back(a);
            end
            a = a + ((p == int'(c_per) - 1) ? c_shift : c_incr);
         end
      end
   endtask

   // first pattern from start, then one per outer step from the outer address
   task automatic build_expected();
      logic [ADDR_W-1:0] oa;
      exp_q.delete();
      if (c_it != '0) begin
         push_pattern(c_start);
         oa = c_start;
         for (int j = 0; j < int'(c_it2); j++) begin
            for (int q = 0; q < int'(c_per2); q++) begin
               push_pattern(oa);
               oa = oa + ((q == int'(c_per2) - 1) ? c_shift2 : c_incr2);
            end
         end
      end
      refresh_head();
   endtask

   task automatic run_pattern(input string name);
      test_name = name;
      build_expected();
      @(posedge clk_i);
      iterations_i  <= c_it;
      period_i      <= c_per;
      duty_i        <= c_duty;
      delay_i       <= c_delay;
      start_i       <= c_start;
      shift_i       <= c_shift;
      incr_i        <= c_incr;
      iterations2_i <= c_it2;
      period2_i     <= c_per2;
      shift2_i      <= c_shift2;
      incr2_i       <= c_incr2;
      run_i         <= 1'b1;
      @(posedge clk_i);
      run_i <= 1'b0;
      if (c_it == '0) begin
         repeat (20) @(posedge clk_i);
      end else begin
         do @(negedge clk_i); while (!done_o);
         repeat (2) @(posedge clk_i);
      end
      a_all_beats: assert (exp_q.size() == 0) else begin
         err_other++;
         $display("%s: %0d expected read beats never arrived", test_name, exp_q.size());
      end
   endtask

   task automatic random_config();
      c_per    = PERIOD_W'(1 + ($unsigned($random(seed)) % 4));
      c_it     = ADDR_W'(1 + ($unsigned($random(seed)) % 3));
      c_duty   = PERIOD_W'($unsigned($random(seed)) % (int'(c_per) + 1));
      c_delay  = PERIOD_W'($unsigned($random(seed)) % 4);
      c_start  = ADDR_W'($random(seed));
      c_shift  = ADDR_W'($random(seed));
      c_incr   = ADDR_W'($random(seed));
      c_it2    = ADDR_W'($unsigned($random(seed)) % 3);
      c_per2   = PERIOD_W'(1 + ($unsigned($random(seed)) % 2));
      c_shift2 = ADDR_W'($random(seed));
      c_incr2  = ADDR_W'($random(seed));
   endtask

   // a beat is checked at the edge after it, popped at the following negedge
   always @(negedge clk_i) begin
      if (pop_pend && exp_q.size() > 0) begin
         void'(exp_q.pop_front());
         refresh_head();
      end
      pop_pend = rd_valid_o;
   end

   a_expected: assert property (@(posedge clk_i) disable iff (rst_i)
      rd_valid_o |-> !exp_empty) else begin
      err_other++;
      $display("%s: read beat at address %h with none expected", test_name, rd_addr_o);
   end

   a_addr: assert property (@(posedge clk_i) disable iff (rst_i)
      rd_valid_o && !exp_empty |-> rd_addr_o == exp_addr) else begin
      err_addr++;
      $display("ERR %s addr expected %h actual %h", test_name, $sampled(exp_addr),
               $sampled(rd_addr_o));
   end

   a_data: assert property (@(posedge clk_i) disable iff (rst_i)
      rd_valid_o && !exp_empty |-> rd_data_o == exp_data) else begin
      err_data++;
      $display("ERR %s data expected %h actual %h", test_name, $sampled(exp_data),
               $sampled(rd_data_o));
   end

   // a new outer iteration count may drop done as the run pulse goes out
   a_done_hold: assert property (@(posedge clk_i) disable iff (rst_i)
      done_o && !run_i |=> done_o || run_i) else begin
      err_other++;
      $display("%s: done dropped without a new run", test_name);
   end

   a_done_drop: assert property (@(posedge clk_i) disable iff (rst_i)
      run_i |=> !done_o) else begin
      err_other++;
      $display("%s: done still high after a new run", test_name);
   end

   initial begin
      #((DEPTH + 20 + NUM_RUNS * RUN_CYCLES) * CLK_PERIOD);
      $display("watchdog expired before the tests finished");
      $display("TEST FAILED");
      $finish;
   end

   initial begin
      clk_i   = 1'b0;
      rst_i   = 1'b1;
      run_i   = 1'b0;
      wr_en_i = 1'b0;
      {wr_addr_i, wr_data_i, start_i, shift_i, incr_i, shift2_i, incr2_i} = '0;
      {iterations_i, period_i, duty_i, delay_i, iterations2_i, period2_i} = '0;
      seed      = 32'hd26c;
      pop_pend  = 1'b0;
      exp_empty = 1'b1;
      exp_addr  = '0;
      exp_data  = '0;
      test_name = "reset";
      err_addr  = 0;
      err_data  = 0;
      err_other = 0;
      repeat (4) @(posedge clk_i);
      rst_i <= 1'b0;
      // load the whole memory with random words
      for (int a = 0; a < DEPTH; a++) begin
         @(posedge clk_i);
         mirror[a] = DATA_W'($random(seed));
         wr_en_i   <= 1'b1;
         wr_addr_i <= ADDR_W'(a);
         wr_data_i <= mirror[a];
      end
      @(posedge clk_i);
      wr_en_i <= 1'b0;

      c_it     = 3;
      c_per    = 4;
      c_duty   = 4;
      c_delay  = 2;
      c_start  = 10;
      c_incr   = 1;
      c_shift  = 5;
      c_it2    = 0;
      c_per2   = 1;
      c_shift2 = 0;
      c_incr2  = 0;
      run_pattern("single");
      c_duty  = 2;
      c_delay = 0;
      c_start = 100;
      c_incr  = 3;
      c_shift = 20;
      run_pattern("duty");
      c_it    = 2;
      c_per   = 3;
      c_duty  = 3;
      c_delay = 1;
      c_start = 4;
      c_incr  = ADDR_W'(-3);
      c_shift = ADDR_W'(-9);
      run_pattern("wrap");
      c_duty   = 2;
      c_start  = 50;
      c_incr   = 1;
      c_shift  = 10;
      c_it2    = 2;
      c_per2   = 2;
      c_incr2  = 64;
      c_shift2 = ADDR_W'(-100);
      run_pattern("two_level");
      c_it = 0;
      run_pattern("no_inner");
      for (int r = 0; r < 5; r++) begin
         random_config();
         run_pattern($sformatf("random_%0d", r));
      end

      $display("errors: addr %0d data %0d other %0d", err_addr, err_data, err_other);
      if (err_addr + err_data + err_other == 0) begin
         $display("TEST PASSED");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

// File: verilog/agu_top.sv
`timescale 1ns/100ps

module agu_top #(
   parameter int ADDR_W   = agu_pkg::ADDR_W_DEF,
   parameter int PERIOD_W = agu_pkg::PERIOD_W_DEF,
   parameter int DATA_W   = agu_pkg::DATA_W_DEF
) (
   input  logic                     clk_i,
   input  logic                     rst_i,
   input  logic                     run_i,
   input  logic                     wr_en_i,
   input  logic        [ADDR_W-1:0]   wr_addr_i,
   input  logic        [DATA_W-1:0]   wr_data_i,
   input  logic        [ADDR_W-1:0]   iterations_i,
   input  logic        [PERIOD_W-1:0] period_i,
   input  logic        [PERIOD_W-1:0] duty_i,
   input  logic        [PERIOD_W-1:0] delay_i,
   input  logic        [ADDR_W-1:0]   start_i,
   input  logic signed [ADDR_W-1:0]   shift_i,
   input  logic signed [ADDR_W-1:0]   incr_i,
   input  logic        [ADDR_W-1:0]   iterations2_i,
   input  logic        [PERIOD_W-1:0] period2_i,
   input  logic signed [ADDR_W-1:0]   shift2_i,
   input  logic signed [ADDR_W-1:0]   incr2_i,
   output logic        [ADDR_W-1:0]   rd_addr_o,
   output logic        [DATA_W-1:0]   rd_data_o,
   output logic                     rd_valid_o,
   output logic                     done_o
);

   gen_cfg_if #(.ADDR_W(ADDR_W), .PERIOD_W(PERIOD_W)) cfg_in ();
   gen_cfg_if #(.ADDR_W(ADDR_W), .PERIOD_W(PERIOD_W)) cfg_out ();

   logic [ADDR_W-1:0] gen_addr;
   logic              gen_en;
   logic [ADDR_W-1:0] rd_addr_q;

   assign cfg_in.iterations = iterations_i;
   assign cfg_in.period     = period_i;
   assign cfg_in.duty       = duty_i;
   assign cfg_in.delay      = delay_i;
   assign cfg_in.start      = start_i;
   assign cfg_in.shift      = shift_i;
   assign cfg_in.incr       = incr_i;

   // outer generator is enabled on every step and shares the delay
   assign cfg_out.iterations = iterations2_i;
   assign cfg_out.period     = period2_i;
   assign cfg_out.duty       = period2_i;
   assign cfg_out.delay      = delay_i;
   assign cfg_out.start      = start_i;
   assign cfg_out.shift      = shift2_i;
   assign cfg_out.incr       = incr2_i;

   addr_gen2 #(.ADDR_W(ADDR_W), .PERIOD_W(PERIOD_W)) u_gen (
      .clk_i   (clk_i),
      .rst_i   (rst_i),
      .run_i   (run_i),
      .cfg_in  (cfg_in),
      .cfg_out (cfg_out),
      .addr_o  (gen_addr),
      .mem_en_o(gen_en),
      .done_o  (done_o)
   );

   data_mem #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) u_mem (
      .clk_i     (clk_i),
      .rst_i     (rst_i),
      .wr_en_i   (wr_en_i),
      .wr_addr_i (wr_addr_i),
      .wr_data_i (wr_data_i),
      .rd_en_i   (gen_en),
      .rd_addr_i (gen_addr),
      .rd_data_o (rd_data_o),
      .rd_valid_o(rd_valid_o)
   );

   // address travels with the registered read data
   always_ff @(posedge clk_i) begin
      if (gen_en) begin
         rd_addr_q <= gen_addr;
      end
   end

   assign rd_addr_o = rd_addr_q;

endmodule

// File: verilog/data_mem.sv
`timescale 1ns/100ps

module data_mem #(
   parameter int ADDR_W = agu_pkg::ADDR_W_DEF,
   parameter int DATA_W = agu_pkg::DATA_W_DEF
) (
   input  logic              clk_i,
   input  logic              rst_i,
   input  logic              wr_en_i,
   input  logic [ADDR_W-1:0] wr_addr_i,
   input  logic [DATA_W-1:0] wr_data_i,
   input  logic              rd_en_i,
   input  logic [ADDR_W-1:0] rd_addr_i,
   output logic [DATA_W-1:0] rd_data_o,
   output logic              rd_valid_o
);

   localparam int DEPTH = 2 ** ADDR_W;

   logic [DATA_W-1:0] mem_q [DEPTH];
   logic [DATA_W-1:0] rd_data_q;

   // read before write on a same-address collision
   always_ff @(posedge clk_i) begin
      if (wr_en_i) begin
         mem_q[wr_addr_i] <= wr_data_i;
      end
      if (rd_en_i) begin
         rd_data_q <= mem_q[rd_addr_i];
      end
   end

   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         rd_valid_o <= 1'b0;
      end else begin
         rd_valid_o <= rd_en_i;
      end
   end

   assign rd_data_o = rd_data_q;

endmodule

// File: verilog/addr_gen2.sv
`timescale 1ns/100ps

module addr_gen2 #(
   parameter int ADDR_W   = agu_pkg::ADDR_W_DEF,
   parameter int PERIOD_W = agu_pkg::PERIOD_W_DEF
) (
   input  logic              clk_i,
   input  logic              rst_i,
   input  logic              run_i,
   gen_cfg_if.gen            cfg_in,
   gen_cfg_if.gen            cfg_out,
   output logic [ADDR_W-1:0] addr_o,
   output logic              mem_en_o,
   output logic              done_o
);

   // inner config with the start address switched to the outer generator
   gen_cfg_if #(.ADDR_W(ADDR_W), .PERIOD_W(PERIOD_W)) cfg_inner ();

   logic [ADDR_W-1:0] addr_out;
   logic              mem_en_out;
   logic              done_in;
   logic              done_out;
   logic              ready_in;
   logic              ready_out;
   logic              load_in;
   logic              pause_out;
   logic              mem_en_in_q;

   // zero iterations means the generator never runs
   assign ready_in  = |cfg_in.iterations;
   assign ready_out = |cfg_out.iterations;

   // first pattern starts from start, each outer step restarts the inner one
   assign load_in = run_i || mem_en_out;

   // outer waits for the inner pattern and its last beat to clear
   assign pause_out = !done_in || mem_en_in_q;

   assign done_o = done_in && (done_out || !ready_out);

   assign cfg_inner.iterations = cfg_in.iterations;
   assign cfg_inner.period     = cfg_in.period;
   assign cfg_inner.duty       = cfg_in.duty;
   assign cfg_inner.delay      = cfg_in.delay;
   assign cfg_inner.start      = run_i ? cfg_in.start : addr_out;
   assign cfg_inner.shift      = cfg_in.shift;
   assign cfg_inner.incr       = cfg_in.incr;

   addr_gen #(.ADDR_W(ADDR_W), .PERIOD_W(PERIOD_W)) gen_in (
      .clk_i   (clk_i),
      .rst_i   (rst_i),
      .load_i  (load_in),
      .run_i   (load_in && ready_in),
      .pause_i (1'b0),
      .cfg     (cfg_inner),
      .addr_o  (addr_o),
      .mem_en_o(mem_en_o),
      .done_o  (done_in)
   );

   addr_gen #(.ADDR_W(ADDR_W), .PERIOD_W(PERIOD_W)) gen_out (
      .clk_i   (clk_i),
      .rst_i   (rst_i),
      .load_i  (run_i),
      .run_i   (run_i && ready_out),
      .pause_i (pause_out),
      .cfg     (cfg_out),
      .addr_o  (addr_out),
      .mem_en_o(mem_en_out),
      .done_o  (done_out)
   );

   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         mem_en_in_q <= 1'b0;
      end else begin
         mem_en_in_q <= mem_en_o;
      end
   end

   a_done_no_en: assert property (@(posedge clk_i) disable iff (rst_i)
      !(done_o && mem_en_o));

endmodule

// File: verilog/addr_gen.sv
`timescale 1ns/100ps

module addr_gen #(
   parameter int ADDR_W   = agu_pkg::ADDR_W_DEF,
   parameter int PERIOD_W = agu_pkg::PERIOD_W_DEF
) (
   input  logic              clk_i,
   input  logic              rst_i,
   input  logic              load_i,
   input  logic              run_i,
   input  logic              pause_i,
   gen_cfg_if.gen            cfg,
   output logic [ADDR_W-1:0] addr_o,
   output logic              mem_en_o,
   output logic              done_o
);

   agu_pkg::gen_state_e state_q;
   agu_pkg::gen_state_e state_d;

   logic [ADDR_W-1:0]   addr_q;
   logic [ADDR_W-1:0]   addr_step;
   logic [ADDR_W-1:0]   iter_cnt_q;
   logic [PERIOD_W-1:0] per_cnt_q;
   logic [PERIOD_W-1:0] delay_cnt_q;

   logic step;
   logic per_last;
   logic iter_last;
   logic delay_last;

   // one address step per unpaused run cycle
   assign step       = (state_q == agu_pkg::GEN_RUN) && !pause_i;
   assign per_last   = (per_cnt_q == cfg.period - PERIOD_W'(1));
   assign iter_last  = (iter_cnt_q == cfg.iterations - ADDR_W'(1));
   assign delay_last = (delay_cnt_q == cfg.delay - PERIOD_W'(1));

   // shift replaces incr on the last cycle of a period
   assign addr_step = per_last ? cfg.shift : cfg.incr;

   assign addr_o   = addr_q;
   assign mem_en_o = step && (per_cnt_q < cfg.duty);
   assign done_o   = (state_q == agu_pkg::GEN_DONE);

   always_comb begin
      state_d = state_q;
      if (run_i) begin
         state_d = (cfg.delay == '0) ? agu_pkg::GEN_RUN : agu_pkg::GEN_DELAY;
      end else if (load_i) begin
         state_d = agu_pkg::GEN_IDLE;
      end else begin
         case (state_q)
            agu_pkg::GEN_DELAY: begin
               if (delay_last) begin
                  state_d = agu_pkg::GEN_RUN;
               end
            end
            agu_pkg::GEN_RUN: begin
               if (step && per_last && iter_last) begin
                  state_d = agu_pkg::GEN_DONE;
               end
            end
            default: begin
               state_d = state_q;
            end
         endcase
      end
   end

   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         state_q     <= agu_pkg::GEN_IDLE;
         addr_q      <= '0;
         iter_cnt_q  <= '0;
         per_cnt_q   <= '0;
         delay_cnt_q <= '0;
      end else begin
         state_q <= state_d;

         if (load_i) begin
            addr_q <= cfg.start;
         end else if (step) begin
            addr_q <= addr_q + addr_step;
         end

         // counters restart on every load or run
         if (load_i || run_i) begin
            iter_cnt_q  <= '0;
            per_cnt_q   <= '0;
            delay_cnt_q <= '0;
         end else if (state_q == agu_pkg::GEN_DELAY) begin
            delay_cnt_q <= delay_cnt_q + PERIOD_W'(1);
         end else if (step) begin
            if (per_last) begin
               per_cnt_q  <= '0;
               iter_cnt_q <= iter_cnt_q + ADDR_W'(1);
            end else begin
               per_cnt_q <= per_cnt_q + PERIOD_W'(1);
            end
         end
      end
   end

   // enables only in run, with both counters still inside the pattern
   a_en_in_run: assert property (@(posedge clk_i) disable iff (rst_i)
      mem_en_o |-> (state_q == agu_pkg::GEN_RUN) && (iter_cnt_q < cfg.iterations) &&
                   (per_cnt_q < cfg.period));

endmodule

// File: verilog/gen_cfg_if.sv
`timescale 1ns/100ps

interface gen_cfg_if #(
   parameter int ADDR_W   = agu_pkg::ADDR_W_DEF,
   parameter int PERIOD_W = agu_pkg::PERIOD_W_DEF
);

   // number of periods in one pattern
   logic        [ADDR_W-1:0]   iterations;
   logic        [PERIOD_W-1:0] period;
   // enabled cycles at the start of each period
   logic        [PERIOD_W-1:0] duty;
   logic        [PERIOD_W-1:0] delay;
   logic        [ADDR_W-1:0]   start;
   // step on the last cycle of a period
   logic signed [ADDR_W-1:0]   shift;
   // step on every other cycle
   logic signed [ADDR_W-1:0]   incr;

   modport src (output iterations, period, duty, delay, start, shift, incr);

   modport gen (input iterations, period, duty, delay, start, shift, incr);

endinterface

// File: verilog/agu_pkg.sv
package agu_pkg;

   // state of one address generator
   typedef enum logic [1:0] {
      GEN_IDLE,
      GEN_DELAY,
      GEN_RUN,
      GEN_DONE
   } gen_state_e;

   // default memory address width
   localparam int ADDR_W_DEF = 10;

   // default width of period, duty and delay counters
   localparam int PERIOD_W_DEF = 10;

   // default memory word width
   localparam int DATA_W_DEF = 16;

endpackage
